// ==== Makefile ====
# Verilator build and run of the mipsCore testbench
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := mipsCoreTb
FILELIST := mipsCore.f
OBJDIR   := obj_dir
PASS_MSG := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== mipsCore.f ====
+incdir+rtl
rtl/mipsIsaPkg.sv
rtl/mipsCtrlPkg.sv
rtl/mipsDecoder.sv
rtl/mipsRegFile.sv
rtl/mipsAlu.sv
rtl/mipsPcUnit.sv
rtl/mipsWriteback.sv
rtl/mipsCore.sv
verification/mipsCoreTb.sv

// ==== rtl/mipsAlu.sv ====
// execute stage, no overflow trap on add/sub
// zero is raw here, only the PC unit qualifies it with branch
`timescale 1ns/100ps
`default_nettype none

module mipsAlu (
  input  logic [31:0]        opA,
  input  logic [31:0]        opB,
  input  mipsCtrlPkg::aluOpE aluOp,
  output logic [31:0]        result,
  output logic               zero
);

  // signed compare for slt
  logic lessThan;

  assign lessThan = $signed(opA) < $signed(opB);

  always_comb begin
    case (aluOp)
      mipsCtrlPkg::aluAdd: result = opA + opB;
      mipsCtrlPkg::aluSub: result = opA - opB;
      mipsCtrlPkg::aluAnd: result = opA & opB;
      mipsCtrlPkg::aluOr:  result = opA | opB;
      mipsCtrlPkg::aluSlt: result = {31'd0, lessThan};
      // aluNone and anything undefined
      default:             result = 32'd0;
    endcase
  end

  // beq equality via sub
  assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// ==== rtl/mipsCore.sv ====
// single-cycle MIPS top, imem/dmem external and must answer in the same cycle
// memAddr is a word address; the low two byte bits are dropped
`timescale 1ns/100ps
`default_nettype none
`include "mipsCore_config.svh"

module mipsCore (
  input  logic                     clk,
  input  logic                     rst,
  output logic [31:0]              instrAddr,
  input  logic [31:0]              instr,
  output logic [`MIPS_DMEM_AW-1:0] memAddr,
  output logic [31:0]              memWrData,
  output logic                     memWe,
  output logic                     memRe,
  input  logic [31:0]              memRdData,
  output logic                     rfWrEn,
  output logic [4:0]               rfWrAddr,
  output logic [31:0]              rfWrData
);

  // ==========================================================================
  // internal nets
  // ==========================================================================
  mipsIsaPkg::instrT instrW;
  mipsCtrlPkg::ctrlT ctrl;
  logic [31:0]       imm;
  logic [31:0]       rsData;
  logic [31:0]       rtData;
  logic [31:0]       aluOpB;
  logic [31:0]       aluResult;
  logic              aluZero;
  logic [31:0]       pcPlus8;

  assign instrW = instr;

  // ==========================================================================
  // decode and operand fetch
  // ==========================================================================
  mipsDecoder i_mipsDecoder (.instr(instrW), .ctrl(ctrl), .imm(imm));

  mipsRegFile i_mipsRegFile (
    .clk(clk), .rst(rst), .wrEn(rfWrEn), .wrAddr(rfWrAddr), .wrData(rfWrData),
    .rdAddrA(instrW.rs), .rdAddrB(instrW.rt), .rdDataA(rsData), .rdDataB(rtData)
  );

  // ==========================================================================
  // execute, next PC, result
  // ==========================================================================
  // imm for lw/sw, rt otherwise
  assign aluOpB = ctrl.aluSrcImm ? imm : rtData;

  mipsAlu i_mipsAlu (
    .opA(rsData), .opB(aluOpB), .aluOp(ctrl.aluOp), .result(aluResult), .zero(aluZero)
  );

  mipsPcUnit i_mipsPcUnit (
    .clk(clk), .rst(rst), .ctrl(ctrl), .zero(aluZero), .imm(imm),
    .jumpField(instr[25:0]), .rsData(rsData), .pc(instrAddr), .pcPlus8(pcPlus8)
  );

  mipsWriteback i_mipsWriteback (
    .ctrl(ctrl), .aluResult(aluResult), .memRdData(memRdData), .rt(instrW.rt),
    .rd(instrW.rd), .pcPlus8(pcPlus8), .wrEn(rfWrEn), .wrAddr(rfWrAddr),
    .wrData(rfWrData), .memWe(memWe), .memRe(memRe)
  );

  // word address out of the byte address
  assign memAddr   = aluResult[`MIPS_DMEM_AW+1:2];
  assign memWrData = rtData;

endmodule

`default_nettype wire

// ==== rtl/mipsCore_config.svh ====
// core-wide constants for the single-cycle MIPS core
// data memory is word addressed, so byte offsets are dropped before MIPS_DMEM_AW
`ifndef MIPS_CORE_CONFIG_SVH
`define MIPS_CORE_CONFIG_SVH

// fetch starts here once rst is released
`define MIPS_RESET_PC 32'h0000_0000

// word-address bits handed to the external data memory
`define MIPS_DMEM_AW 7

// jal link target ($ra)
`define MIPS_LINK_REG 5'd31

`endif

// ==== rtl/mipsCtrlPkg.sv ====
// control word shared by decoder, ALU, PC unit and writeback
`default_nettype none

package mipsCtrlPkg;

  // ALU function, aluNone forces a zero result
  typedef enum logic [2:0] {
    aluAdd  = 3'd0,
    aluSub  = 3'd1,
    aluAnd  = 3'd2,
    aluOr   = 3'd3,
    aluSlt  = 3'd4,
    aluNone = 3'd5
  } aluOpE;

  // which register index receives the result
  typedef enum logic [1:0] {
    destRt   = 2'd0,
    destRd   = 2'd1,
    destLink = 2'd2
  } wrDestE;

  typedef struct packed {
    aluOpE  aluOp;
    logic   aluSrcImm;  // opB from sign-extended imm
    logic   regWrite;
    wrDestE wrDest;
    logic   memToReg;   // load data onto write port
    logic   memRead;
    logic   memWrite;
    logic   branch;     // beq, taken on ALU zero
    logic   jump;       // j / jal pseudo-direct
    logic   jumpReg;    // jr
    logic   link;       // write pcPlus8
  } ctrlT;

endpackage

`default_nettype wire

// ==== rtl/mipsDecoder.sv ====
// combinational decode, unknown encodings become a no-op (no writes, aluNone)
`timescale 1ns/100ps
`default_nettype none

module mipsDecoder (
  input  mipsIsaPkg::instrT  instr,
  output mipsCtrlPkg::ctrlT  ctrl,
  output logic [31:0]        imm
);

  // i-type immediate, sign extended
  assign imm = {{16{instr[15]}}, instr[15:0]};

  always_comb begin
    // safe defaults, nothing written
    ctrl        = '0;
    ctrl.aluOp  = mipsCtrlPkg::aluNone;
    ctrl.wrDest = mipsCtrlPkg::destRt;

    case (instr.opcode)
      mipsIsaPkg::rType: begin
        ctrl.wrDest = mipsCtrlPkg::destRd;
        ctrl.regWrite = 1'b1;
        case (instr.funct)
          mipsIsaPkg::fnAdd: ctrl.aluOp = mipsCtrlPkg::aluAdd;
          mipsIsaPkg::fnSub: ctrl.aluOp = mipsCtrlPkg::aluSub;
          mipsIsaPkg::fnAnd: ctrl.aluOp = mipsCtrlPkg::aluAnd;
          mipsIsaPkg::fnOr:  ctrl.aluOp = mipsCtrlPkg::aluOr;
          mipsIsaPkg::fnSlt: ctrl.aluOp = mipsCtrlPkg::aluSlt;
          mipsIsaPkg::fnJr: begin
            // register jump, no write-back
            ctrl.regWrite = 1'b0;
            ctrl.jumpReg  = 1'b1;
          end
          default: ctrl.regWrite = 1'b0;
        endcase
      end
      mipsIsaPkg::lw: begin
        // addr = rs + imm
        ctrl.aluOp     = mipsCtrlPkg::aluAdd;
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.memRead   = 1'b1;
      end
      mipsIsaPkg::sw: begin
        ctrl.aluOp     = mipsCtrlPkg::aluAdd;
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
      end
      mipsIsaPkg::beq: begin
        // compare by subtraction, zero flag decides
        ctrl.aluOp  = mipsCtrlPkg::aluSub;
        ctrl.branch = 1'b1;
      end
      mipsIsaPkg::j: ctrl.jump = 1'b1;
      mipsIsaPkg::jal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.wrDest   = mipsCtrlPkg::destLink;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/mipsIsaPkg.sv ====
// instruction encodings for the supported MIPS subset only
// funct names carry an fn prefix since and/or are reserved words
`default_nettype none

package mipsIsaPkg;

  // ==========================================================================
  // primary opcode, bits 31:26
  // ==========================================================================
  typedef enum logic [5:0] {
    rType = 6'h00,
    j     = 6'h02,
    jal   = 6'h03,
    beq   = 6'h04,
    lw    = 6'h23,
    sw    = 6'h2b
  } opcodeE;

  // r-type function, bits 5:0
  typedef enum logic [5:0] {
    fnJr  = 6'h08,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } functE;

  // r-type view of the word
  // i-type imm and j-type target overlay the low fields
  typedef struct packed {
    opcodeE     opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    functE      funct;
  } instrT;

endpackage

`default_nettype wire

// ==== rtl/mipsPcUnit.sv ====
// PC register and next-PC select, no delay slot
// priority is jr, then j/jal, then taken beq, then pc + 4
`timescale 1ns/100ps
`default_nettype none
`include "mipsCore_config.svh"

module mipsPcUnit (
  input  logic              clk,
  input  logic              rst,
  input  mipsCtrlPkg::ctrlT ctrl,
  input  logic              zero,
  input  logic [31:0]       imm,
  input  logic [25:0]       jumpField,
  input  logic [31:0]       rsData,
  output logic [31:0]       pc,
  output logic [31:0]       pcPlus8
);

  logic [31:0] pcPlus4;
  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic [31:0] nextPc;

  assign pcPlus4      = pc + 32'd4;
  assign pcPlus8      = pc + 32'd8;  // jal link value
  assign branchTarget = pcPlus4 + {imm[29:0], 2'b00};
  // pseudo-direct, stays in current 256 MB region
  assign jumpTarget   = {pcPlus4[31:28], jumpField, 2'b00};

  always_comb begin
    if (ctrl.jumpReg)                 nextPc = rsData;
    else if (ctrl.jump)               nextPc = jumpTarget;
    else if (ctrl.branch && zero)     nextPc = branchTarget;
    else                              nextPc = pcPlus4;
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) pc <= `MIPS_RESET_PC;
    else      pc <= nextPc;
  end

endmodule

`default_nettype wire

// ==== rtl/mipsRegFile.sv ====
// 32 x 32 GPRs, two async read ports, one write port at posedge clk
// r0 reads as zero; writes to it are dropped
`timescale 1ns/100ps
`default_nettype none

module mipsRegFile (
  input  logic        clk,
  input  logic        rst,
  input  logic        wrEn,
  input  logic [4:0]  wrAddr,
  input  logic [31:0] wrData,
  input  logic [4:0]  rdAddrA,
  input  logic [4:0]  rdAddrB,
  output logic [31:0] rdDataA,
  output logic [31:0] rdDataB
);

  logic [31:0] regs [32];

  // async clear of the whole file
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wrEn && (wrAddr != 5'd0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // read ports, r0 hardwired
  assign rdDataA = (rdAddrA == 5'd0) ? 32'd0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == 5'd0) ? 32'd0 : regs[rdAddrB];

endmodule

`default_nettype wire

// ==== rtl/mipsWriteback.sv ====
// result stage, picks register destination and data, drives memory strobes
// strobes are active-high levels for the current instruction only
`timescale 1ns/100ps
`default_nettype none
`include "mipsCore_config.svh"

module mipsWriteback (
  input  mipsCtrlPkg::ctrlT ctrl,
  input  logic [31:0]       aluResult,
  input  logic [31:0]       memRdData,
  input  logic [4:0]        rt,
  input  logic [4:0]        rd,
  input  logic [31:0]       pcPlus8,
  output logic              wrEn,
  output logic [4:0]        wrAddr,
  output logic [31:0]       wrData,
  output logic              memWe,
  output logic              memRe
);

  // destination index
  always_comb begin
    case (ctrl.wrDest)
      mipsCtrlPkg::destRd:   wrAddr = rd;
      mipsCtrlPkg::destLink: wrAddr = `MIPS_LINK_REG;
      default:               wrAddr = rt;
    endcase
  end

  // link beats load beats ALU
  assign wrData = ctrl.link ? pcPlus8 : (ctrl.memToReg ? memRdData : aluResult);
  assign wrEn   = ctrl.regWrite;
  assign memWe  = ctrl.memWrite;
  assign memRe  = ctrl.memRead;

endmodule

`default_nettype wire

// ==== verification/mipsCoreTb.sv ====
// memories are zero-latency arrays that answer in the same cycle
// programs must stay inside the first 1 KB of instruction space
`timescale 1ns/100ps
`default_nettype none
`include "mipsCore_config.svh"

module mipsCoreTb;

  localparam int ClkPeriod   = 100;
  localparam int ResetCycles = 3;
  localparam int NumTests    = 5;
  // words over all five programs
  localparam int ProgWords   = 63;
  // twice the program length plus reset and halt detection per test
  localparam int WatchdogNs  = (ProgWords * 2 + NumTests * (ResetCycles + 2)) * ClkPeriod;

  logic clk;
  logic rst;
  logic [31:0] instrAddr;
  logic [31:0] instr;
  logic [`MIPS_DMEM_AW-1:0] memAddr;
  logic [31:0] memWrData;
  logic memWe;
  logic memRe;
  logic [31:0] memRdData;
  logic rfWrEn;
  logic [4:0] rfWrAddr;
  logic [31:0] rfWrData;

  // memories and reference model state
  logic [31:0] imem [256];
  logic [31:0] dmem [128];
  logic [31:0] initMem [128];
  logic [31:0] refMem [128];
  logic [31:0] refRegs [32];
  logic [31:0] refPc;
  logic [31:0] haltAddr;
  logic [31:0] seed = 32'd42897;
  int progLen;
  int errors;
  int checks;
  int testsFailed;

  // expected values for the instruction at refPc
  logic expWrEn;
  logic expMemWe;
  logic expMemRe;
  logic [4:0] expWrAddr;
  logic [31:0] expWrData;
  logic [31:0] expMemData;
  logic [31:0] expNext;
  logic [`MIPS_DMEM_AW-1:0] expMemAddr;

  mipsCore i_mipsCore (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr), .memAddr(memAddr),
    .memWrData(memWrData), .memWe(memWe), .memRe(memRe), .memRdData(memRdData),
    .rfWrEn(rfWrEn), .rfWrAddr(rfWrAddr), .rfWrData(rfWrData)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // ==========================================================================
  // memory models
  // ==========================================================================
  assign instr     = imem[instrAddr[9:2]];
  assign memRdData = dmem[memAddr];

  // preset image loaded while in reset
  always @(posedge clk) begin
    if (!rst) dmem <= initMem;
    else if (memWe) dmem[memAddr] <= memWrData;
  end

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // encoders take register and immediate arguments as plain ints
  function automatic logic [31:0] rInstr(mipsIsaPkg::functE fn, int rd, int rs, int rt);
    return {mipsIsaPkg::rType, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
  endfunction

  function automatic logic [31:0] iInstr(mipsIsaPkg::opcodeE op, int rs, int rt, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic logic [31:0] jInstr(mipsIsaPkg::opcodeE op, int target);
    return {op, target[25:0]};
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[8'(progLen)] = w;
    progLen++;
  endtask

  // self loop marks the end of a program
  task automatic emitHalt();
    haltAddr = 32'(progLen * 4);
    emit(jInstr(mipsIsaPkg::j, progLen));
  endtask

  // every unused word jumps to itself and odd data words are negative
  task automatic fillMemories();
    for (int i = 0; i < 256; i++) imem[8'(i)] = jInstr(mipsIsaPkg::j, i);
    for (int i = 0; i < 128; i++) begin
      initMem[7'(i)] = nextRand();
      initMem[7'(i)][31] = i[0];
    end
    // word 1 never equals word 0 but word 2 always does
    initMem[1] = ~initMem[0];
    initMem[2] = initMem[0];
    progLen = 0;
  endtask

  // ==========================================================================
  // reference model
  // ==========================================================================
  task automatic predict();
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] seq;
    logic [31:0] ea;
    w   = imem[refPc[9:2]];
    a   = refRegs[w[25:21]];
    b   = refRegs[w[20:16]];
    se  = {{16{w[15]}}, w[15:0]};
    seq = refPc + 32'd4;
    ea  = (a + se) >> 2;
    expWrEn    = 1'b0;
    expMemWe   = 1'b0;
    expMemRe   = 1'b0;
    expWrAddr  = w[15:11];
    expWrData  = 32'd0;
    expMemData = b;
    expMemAddr = ea[`MIPS_DMEM_AW-1:0];
    expNext    = seq;
    case (w[31:26])
      mipsIsaPkg::rType: begin
        expWrEn = 1'b1;
        case (w[5:0])
          mipsIsaPkg::fnAdd: expWrData = a + b;
          mipsIsaPkg::fnSub: expWrData = a - b;
          mipsIsaPkg::fnAnd: expWrData = a & b;
          mipsIsaPkg::fnOr:  expWrData = a | b;
          mipsIsaPkg::fnSlt: expWrData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          mipsIsaPkg::fnJr: begin
            expWrEn = 1'b0;
            expNext = a;
          end
          default: expWrEn = 1'b0;
        endcase
      end
      mipsIsaPkg::lw: begin
        expWrEn   = 1'b1;
        expMemRe  = 1'b1;
        expWrAddr = w[20:16];
        expWrData = refMem[expMemAddr];
      end
      mipsIsaPkg::sw: expMemWe = 1'b1;
      mipsIsaPkg::beq: if (a == b) expNext = seq + {se[29:0], 2'b00};
      mipsIsaPkg::j: expNext = {seq[31:28], w[25:0], 2'b00};
      mipsIsaPkg::jal: begin
        expNext   = {seq[31:28], w[25:0], 2'b00};
        expWrEn   = 1'b1;
        expWrAddr = `MIPS_LINK_REG;
        expWrData = refPc + 32'd8;
      end
      default: ;
    endcase
  endtask

  // model state steps with the DUT and never stores r0
  always @(posedge clk) begin
    if (!rst) begin
      refPc   = `MIPS_RESET_PC;
      refMem  = initMem;
      refRegs = '{default: 32'd0};
    end else begin
      if (expWrEn && expWrAddr != 5'd0) refRegs[expWrAddr] = expWrData;
      if (expMemWe) refMem[expMemAddr] = expMemData;
      refPc = expNext;
    end
  end

  task automatic reportMismatch(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    errors++;
  endtask

  // ==========================================================================
  // checks at the falling edge where all ports are settled
  // ==========================================================================
  always @(negedge clk) begin
    if (rst) begin
      predict();
      checks++;
      assert (instrAddr === refPc) else reportMismatch("instrAddr", instrAddr, refPc);
      assert (rfWrEn === expWrEn) else reportMismatch("rfWrEn", 32'(rfWrEn), 32'(expWrEn));
      assert (memWe === expMemWe) else reportMismatch("memWe", 32'(memWe), 32'(expMemWe));
      assert (memRe === expMemRe) else reportMismatch("memRe", 32'(memRe), 32'(expMemRe));
      if (expWrEn) begin
        assert (rfWrAddr === expWrAddr)
          else reportMismatch("rfWrAddr", 32'(rfWrAddr), 32'(expWrAddr));
        assert (rfWrData === expWrData) else reportMismatch("rfWrData", rfWrData, expWrData);
      end
      if (expMemWe || expMemRe) begin
        assert (memAddr === expMemAddr)
          else reportMismatch("memAddr", 32'(memAddr), 32'(expMemAddr));
      end
      if (expMemWe) begin
        assert (memWrData === expMemData) else reportMismatch("memWrData", memWrData, expMemData);
      end
    end
  end

  // ==========================================================================
  // programs
  // ==========================================================================
  task automatic loadProgram(input int t, output string name);
    fillMemories();
    case (t)
      0: begin
        name = "alu ops";
        for (int k = 0; k < 4; k++) begin
          emit(iInstr(mipsIsaPkg::lw, 0, 1, 8 * k));
          emit(iInstr(mipsIsaPkg::lw, 0, 2, 8 * k + 4));
          emit(rInstr(mipsIsaPkg::fnAdd, 3, 1, 2));
          emit(rInstr(mipsIsaPkg::fnSub, 4, 1, 2));
          emit(rInstr(mipsIsaPkg::fnAnd, 5, 1, 2));
          emit(rInstr(mipsIsaPkg::fnOr, 6, 1, 2));
          emit(rInstr(mipsIsaPkg::fnSlt, 7, 1, 2));
          emit(rInstr(mipsIsaPkg::fnSlt, 8, 2, 1));
        end
      end
      1: begin
        name = "store load";
        emit(iInstr(mipsIsaPkg::lw, 0, 1, 0));
        emit(iInstr(mipsIsaPkg::lw, 0, 2, 4));
        emit(iInstr(mipsIsaPkg::sw, 0, 1, 64));
        emit(iInstr(mipsIsaPkg::sw, 0, 2, 68));
        emit(iInstr(mipsIsaPkg::lw, 0, 3, 64));
        emit(iInstr(mipsIsaPkg::lw, 0, 4, 68));
        emit(rInstr(mipsIsaPkg::fnAdd, 5, 3, 4));
      end
      2: begin
        name = "beq";
        emit(iInstr(mipsIsaPkg::lw, 0, 1, 0));
        emit(iInstr(mipsIsaPkg::lw, 0, 2, 4));
        emit(iInstr(mipsIsaPkg::lw, 0, 3, 8));
        // unequal operands fall through
        emit(iInstr(mipsIsaPkg::beq, 1, 2, 1));
        emit(rInstr(mipsIsaPkg::fnAdd, 4, 1, 1));
        // equal operands skip one word
        emit(iInstr(mipsIsaPkg::beq, 1, 3, 1));
        emit(rInstr(mipsIsaPkg::fnAdd, 5, 1, 1));
        emit(rInstr(mipsIsaPkg::fnAdd, 6, 2, 2));
      end
      3: begin
        name = "j jal jr";
        emit(jInstr(mipsIsaPkg::j, 2));
        emit(rInstr(mipsIsaPkg::fnAdd, 9, 0, 0));
        emit(jInstr(mipsIsaPkg::jal, 6));
        emit(rInstr(mipsIsaPkg::fnAdd, 10, 0, 0));
        // return lands here at pc + 8 of the jal
        emit(rInstr(mipsIsaPkg::fnAdd, 11, 31, 0));
        emitHalt();
        emit(rInstr(mipsIsaPkg::fnJr, 0, 31, 0));
      end
      4: begin
        name = "register zero";
        emit(iInstr(mipsIsaPkg::lw, 0, 1, 0));
        emit(rInstr(mipsIsaPkg::fnAdd, 0, 1, 1));
        emit(iInstr(mipsIsaPkg::lw, 0, 0, 4));
        emit(rInstr(mipsIsaPkg::fnAdd, 2, 0, 0));
        emit(rInstr(mipsIsaPkg::fnAdd, 3, 0, 1));
      end
      default: name = "empty";
    endcase
    if (t != 3) emitHalt();
  endtask

  task automatic runTest(input int t);
    int errBefore;
    string name;
    errBefore = errors;
    @(posedge clk);
    #1;
    rst = 1'b0;
    loadProgram(t, name);
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst = 1'b1;
    @(negedge clk);
    assert (instrAddr === `MIPS_RESET_PC)
      else reportMismatch("reset instrAddr", instrAddr, `MIPS_RESET_PC);
    while (instrAddr !== haltAddr) @(negedge clk);
    // let the checks of the halt cycle finish first
    #1;
    if (errors != errBefore) testsFailed++;
    $display("test %0d (%s): %s, %0d mismatches", t, name,
             (errors == errBefore) ? "ok" : "failed", errors - errBefore);
  endtask

  initial begin
    rst = 1'b0;
    errors = 0;
    checks = 0;
    testsFailed = 0;
    fillMemories();
    for (int t = 0; t < NumTests; t++) runTest(t);
    $display("%0d tests, %0d failed, %0d checked cycles, %0d mismatches",
             NumTests, testsFailed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WatchdogNs);
    $display("timeout: a program did not reach its halt loop in time");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
